//--- src.f
div_msg_pkg.sv
div_ctrl_pkg.sv
int_div_dpath.sv
int_div_ctrl.sv
int_div_resp_queue.sv
int_div_iterative.sv
tb_int_div.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the divider testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary --assert -Wno-fatal \
  --top-module tb_int_div \
  -f src.f \
  --Mdir "$OBJ" -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed" "$LOG"; then
  echo "simulation PASS"
  exit 0
else
  echo "simulation FAIL"
  exit 1
fi

//--- tb_int_div.sv
`timescale 1ns/1ns
`default_nettype none
// ------------------------------
// divider testbench, all checks are concurrent assertions below
// expected results are queued when a request is accepted
// ------------------------------

module tb_int_div;

  import div_msg_pkg::*;

  logic        clk;
  logic        reset;
  div_req_t    req;
  logic        req_val;
  logic        req_rdy;
  div_resp_t   resp;
  logic        resp_val;
  logic        resp_rdy;

  // reference model
  result_t     exp_q [$];
  result_t     exp_head;
  int          exp_count;
  // stall and latency tracking
  logic        stall_prev;
  result_t     resp_prev;
  int          lat_cnt;
  logic        lat_mode;
  // 0 ready held high, 1 ready held low, 2 random ready
  int          rdy_mode;
  logic [31:0] stim_seed;
  logic [31:0] rdy_seed;
  // bookkeeping
  int          err_count;
  int          tests_run;
  int          tests_failed;
  int          test_err_start;

  int_div_iterative int_div_iterative_inst (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // ------------------------------
  // helpers
  // ------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // divide by zero and signed overflow follow the unit's own rules
  function automatic result_t expected_result(input logic is_signed, input operand_t a,
                                              input operand_t b);
    operand_t q;
    operand_t r;
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      q = 32'h8000_0000;
      r = '0;
    end else if (is_signed) begin
      // truncating division, remainder keeps the dividend's sign
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    return {r, q};
  endfunction

  task automatic finish_run();
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    err_count++;
    finish_run();
  endtask

  task automatic begin_test();
    test_err_start = err_count;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_count != test_err_start) begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, err_count - test_err_start);
    end else begin
      $display("test %s ok", name);
    end
  endtask

  // called 1 ns after an edge, returns 1 ns after the accepting edge
  task automatic send_req(input logic is_signed, input operand_t a, input operand_t b);
    int waited;
    waited = 0;
    req.is_signed = is_signed;
    req.a         = a;
    req.b         = b;
    req_val       = 1'b1;
    // req_rdy only depends on the FSM state, so it is settled here
    while (!req_rdy) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > 500) begin
        report_timeout("req_rdy");
      end
    end
    @(posedge clk);
    #1;
    req_val = 1'b0;
  endtask

  // every accepted request has to come back
  task automatic drain(input int max_cycles);
    int waited;
    waited = 0;
    while (exp_count != 0) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > max_cycles) begin
        report_timeout("outstanding responses");
      end
    end
  endtask

  // ------------------------------
  // reference model and monitors
  // ------------------------------

  always @(posedge clk) begin
    if (reset) begin
      exp_q.delete();
      lat_cnt <= 0;
    end else begin
      // oldest out first, new request goes to the back
      if (resp_val && resp_rdy && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      if (req_val && req_rdy) begin
        exp_q.push_back(expected_result(req.is_signed, req.a, req.b));
        lat_cnt <= 0;
      end else if (lat_cnt < 1000) begin
        lat_cnt <= lat_cnt + 1;
      end
    end
    exp_count  <= exp_q.size();
    exp_head   <= (exp_q.size() != 0) ? exp_q[0] : '0;
    stall_prev <= !reset && resp_val && !resp_rdy;
    resp_prev  <= resp.result;
  end

  // ready driver, mode taken at the edge and applied 1 ns later
  initial begin
    int mode_now;
    resp_rdy = 1'b1;
    rdy_seed = lcg_next(32'd78);
    forever begin
      @(posedge clk);
      mode_now = rdy_mode;
      #1;
      if (mode_now == 0) begin
        resp_rdy = 1'b1;
      end else if (mode_now == 1) begin
        resp_rdy = 1'b0;
      end else begin
        rdy_seed = lcg_next(rdy_seed);
        resp_rdy = rdy_seed[16];
      end
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  a_resp_match: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy && exp_count != 0) |-> (resp.result == exp_head))
  else begin
    $display("error %0t resp expected %h actual %h", $time, $sampled(exp_head),
             $sampled(resp));
    err_count++;
  end

  a_resp_expected: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |-> (exp_count != 0))
  else begin
    $display("response at %0t arrived with no request outstanding", $time);
    err_count++;
  end

  // a stalled response must not move or vanish
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    stall_prev |-> (resp_val && resp.result == resp_prev))
  else begin
    $display("error %0t resp expected %h actual %h", $time, $sampled(resp_prev),
             $sampled(resp));
    err_count++;
  end

  // resp_val rises after the 33rd edge and is seen at the 34th
  a_latency: assert property (@(posedge clk) disable iff (reset)
    (lat_mode && $rose(resp_val)) |-> (lat_cnt == 33))
  else begin
    $display("error %0t resp_val latency expected 33 actual %0d", $time, $sampled(lat_cnt));
    err_count++;
  end

  a_rdy_after_resp: assert property (@(posedge clk) disable iff (reset)
    (lat_mode && $rose(resp_val)) |-> req_rdy)
  else begin
    $display("error %0t req_rdy expected 1 actual %b", $time, $sampled(req_rdy));
    err_count++;
  end

  // two queued plus one computing fills the unit
  a_capacity: assert property (@(posedge clk) disable iff (reset)
    (exp_count >= 3) |-> !req_rdy)
  else begin
    $display("error %0t req_rdy expected 0 actual %b", $time, $sampled(req_rdy));
    err_count++;
  end

  a_reset_rdy: assert property (@(posedge clk)
    $fell(reset) |-> req_rdy)
  else begin
    $display("error %0t req_rdy expected 1 actual %b", $time, $sampled(req_rdy));
    err_count++;
  end

  a_reset_val: assert property (@(posedge clk)
    $fell(reset) |-> !resp_val)
  else begin
    $display("error %0t resp_val expected 0 actual %b", $time, $sampled(resp_val));
    err_count++;
  end

  // ------------------------------
  // stimulus
  // ------------------------------

  initial begin
    operand_t ra;
    operand_t rb;
    logic     rs;
    int       gap;
    reset     = 1'b1;
    req       = '0;
    req_val   = 1'b0;
    lat_mode  = 1'b0;
    rdy_mode  = 0;
    stim_seed = 32'd78;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    begin_test();
    repeat (2) @(posedge clk);
    #1;
    end_test("reset state");

    // every sign combination
    begin_test();
    send_req(1'b0, 100, 7);
    send_req(1'b0, 32'hffff_ffff, 3);
    send_req(1'b0, 12345678, 1);
    send_req(1'b1, 100, 7);
    send_req(1'b1, -100, 7);
    send_req(1'b1, 100, -7);
    send_req(1'b1, -100, -7);
    send_req(1'b1, -7, 2);
    drain(400);
    end_test("directed");

    begin_test();
    send_req(1'b1, 5, 0);
    send_req(1'b0, 5, 0);
    send_req(1'b1, -5, 0);
    send_req(1'b0, 0, 0);
    send_req(1'b1, 32'h8000_0000, -1);
    send_req(1'b0, 32'h8000_0000, 32'hffff_ffff);
    send_req(1'b0, 3, 10);
    send_req(1'b1, -3, 10);
    drain(400);
    end_test("corner cases");

    // one request at a time with an empty queue
    begin_test();
    lat_mode = 1'b1;
    send_req(1'b0, 999, 10);
    drain(100);
    send_req(1'b1, -999, 10);
    drain(100);
    send_req(1'b1, 32'h7fff_ffff, -1);
    drain(100);
    lat_mode = 1'b0;
    end_test("latency");

    begin_test();
    rdy_mode = 1;
    @(posedge clk);
    #1;
    send_req(1'b0, 1000, 3);
    send_req(1'b1, -1000, 7);
    send_req(1'b1, 32'h7fff_ffff, -2);
    // long enough for the third result to sit in the done state
    repeat (68) @(posedge clk);
    #1;
    rdy_mode = 0;
    drain(200);
    end_test("back-pressure");

    begin_test();
    rdy_mode = 2;
    for (int i = 0; i < 200; i++) begin
      stim_seed = lcg_next(stim_seed);
      ra = stim_seed;
      stim_seed = lcg_next(stim_seed);
      rb = stim_seed;
      stim_seed = lcg_next(stim_seed);
      rs = stim_seed[31];
      gap = stim_seed[21:20];
      // bias some divisors toward zero, small values and overflow
      case (stim_seed[26:24])
        3'd0: rb = '0;
        3'd1: rb = {28'b0, rb[3:0]};
        3'd2: begin
          ra = 32'h8000_0000;
          rb = 32'hffff_ffff;
        end
        default: rb = rb;
      endcase
      // idle cycles with req_val low, still driven 1 ns after the edge
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      send_req(rs, ra, rb);
    end
    rdy_mode = 0;
    drain(200);
    end_test("random traffic");

    finish_run();
  end

endmodule

`default_nettype wire

//--- int_div_iterative.sv
`timescale 1ns/1ns
`default_nettype none
// ------------------------------
// iterative 32-bit divider, 33-cycle latency, one division in flight
// valid/ready on both channels, responses buffered two deep
// ------------------------------

module int_div_iterative (
  input  logic                   clk,
  input  logic                   reset,
  input  div_msg_pkg::div_req_t  req,
  input  logic                   req_val,
  output logic                   req_rdy,
  output div_msg_pkg::div_resp_t resp,
  output logic                   resp_val,
  input  logic                   resp_rdy
);

  import div_msg_pkg::*;

  // control to datapath
  logic      load;
  logic      step;
  logic      fix;
  // datapath to control
  logic      last_iter;
  // control and queue
  logic      push;
  logic      full;
  // corrected result waiting for the queue
  div_resp_t result;

  int_div_dpath dpath_inst (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .load      (load),
    .step      (step),
    .fix       (fix),
    .last_iter (last_iter),
    .result    (result)
  );

  int_div_ctrl ctrl_inst (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .last_iter (last_iter),
    .full      (full),
    .load      (load),
    .step      (step),
    .fix       (fix),
    .push      (push)
  );

  // results leave through here only
  int_div_resp_queue queue_inst (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .push_data (result),
    .full      (full),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .resp      (resp)
  );

endmodule

`default_nettype wire

//--- int_div_resp_queue.sv
`timescale 1ns/1ns
`default_nettype none
// ------------------------------
// response FIFO, resp_queue_depth entries
// the producer must hold push low while full is high
// ------------------------------

module int_div_resp_queue (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   push,
  input  div_msg_pkg::div_resp_t push_data,
  output logic                   full,
  output logic                   resp_val,
  input  logic                   resp_rdy,
  output div_msg_pkg::div_resp_t resp
);

  import div_msg_pkg::*;
  import div_ctrl_pkg::*;

  // storage
  div_resp_t mem_q [resp_queue_depth];

  logic [$clog2(resp_queue_depth)-1:0]   wr_ptr_q;
  logic [$clog2(resp_queue_depth)-1:0]   rd_ptr_q;
  logic [$clog2(resp_queue_depth+1)-1:0] count_q;
  logic                                  pop;

  assign full     = (count_q == resp_queue_depth);
  assign resp_val = (count_q != '0);
  // oldest entry always on the output
  assign resp     = mem_q[rd_ptr_q];

  assign pop     = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data;
    end
  end

  // pointers wrap at the last entry
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == resp_queue_depth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == resp_queue_depth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // occupancy bound
  a_count_bound: assert property (@(posedge clk) disable iff (reset)
    count_q <= resp_queue_depth);

  // the producer never pushes into a full queue
  a_no_push_full: assert property (@(posedge clk) disable iff (reset)
    !(push && full));

  // a stalled response stays put until it is taken
  a_resp_stable: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp)));

endmodule

`default_nettype wire

//--- int_div_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
// ------------------------------
// divider FSM, idle -> calc -> done
// last_iter is only looked at in calc
// ------------------------------

module int_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  input  logic last_iter,
  input  logic full,
  output logic load,
  output logic step,
  output logic fix,
  output logic push
);

  import div_ctrl_pkg::*;

  div_state_t state_q;
  div_state_t state_next;

  // ------------------------------
  // outputs
  // ------------------------------

  always_comb begin
    req_rdy = 1'b0;
    load    = 1'b0;
    step    = 1'b0;
    fix     = 1'b0;
    push    = 1'b0;
    unique case (state_q)
      st_idle: begin
        // accepting, operands captured on the same edge
        req_rdy = 1'b1;
        load    = req_val;
      end
      st_calc: begin
        step = 1'b1;
        // final step also latches the corrected result
        fix  = last_iter;
      end
      st_done: begin
        // hold the result while the queue is full
        push = !full;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

  // ------------------------------
  // next state
  // ------------------------------

  always_comb begin
    state_next = state_q;
    unique case (state_q)
      st_idle: begin
        if (load) begin
          state_next = st_calc;
        end
      end
      st_calc: begin
        if (fix) begin
          state_next = st_done;
        end
      end
      st_done: begin
        if (push) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_next;
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  // exactly one calc cycle per quotient bit, set by the datapath counter
  a_calc_length: assert property (@(posedge clk) disable iff (reset)
    load |=> (state_q == st_calc)[*iter_count] ##1 (state_q == st_done));

endmodule

`default_nettype wire

//--- int_div_dpath.sv
`timescale 1ns/1ns
`default_nettype none
// ------------------------------
// restoring shift-subtract datapath, one quotient bit per step
// fix must come together with the final step, result is built from that step's output
// ------------------------------

module int_div_dpath (
  input  logic                   clk,
  input  logic                   reset,
  input  div_msg_pkg::div_req_t  req,
  input  logic                   load,
  input  logic                   step,
  input  logic                   fix,
  output logic                   last_iter,
  output div_msg_pkg::div_resp_t result
);

  import div_msg_pkg::*;
  import div_ctrl_pkg::*;

  // ------------------------------
  // operand normalization
  // ------------------------------

  // magnitudes of the request operands
  operand_t a_mag;
  operand_t b_mag;
  // values actually loaded
  operand_t a_in;
  operand_t b_in;
  // result signs seen at load
  logic     quo_neg_in;
  logic     rem_neg_in;

  // two's complement magnitude, most negative value maps onto itself
  assign a_mag = req.a[data_width-1] ? (~req.a + 1'b1) : req.a;
  assign b_mag = req.b[data_width-1] ? (~req.b + 1'b1) : req.b;

  // unsigned requests go through untouched
  assign a_in = req.is_signed ? a_mag : req.a;
  assign b_in = req.is_signed ? b_mag : req.b;

  // quotient sign, kept positive on divide by zero so the quotient stays all ones
  assign quo_neg_in = req.is_signed && (req.a[data_width-1] ^ req.b[data_width-1]) &&
                      (req.b != '0);
  // remainder follows the dividend
  assign rem_neg_in = req.is_signed && req.a[data_width-1];

  // ------------------------------
  // iteration
  // ------------------------------

  // {partial remainder, dividend/quotient bits}, 65 bits
  logic [2*data_width:0]   rq_q;
  logic [2*data_width:0]   rq_shift;
  logic [2*data_width:0]   rq_next;
  // one extra bit on top of the 33-bit subtraction gives a clean borrow
  logic [data_width+1:0]   diff;
  logic                    borrow;
  operand_t                divisor_q;
  count_t                  count_q;
  logic                    quo_neg_q;
  logic                    rem_neg_q;

  // shift the whole register left by one
  assign rq_shift = {rq_q[2*data_width-1:0], 1'b0};

  // trial subtraction of the divisor from the upper half
  assign diff   = {1'b0, rq_shift[2*data_width:data_width]} - {2'b00, divisor_q};
  assign borrow = diff[data_width+1];

  // borrow means restore, the shifted value already has a zero quotient bit
  assign rq_next = borrow ? rq_shift :
                   {diff[data_width:0], rq_shift[data_width-1:1], 1'b1};

  always_ff @(posedge clk) begin
    if (load) begin
      rq_q      <= {{(data_width+1){1'b0}}, a_in};
      divisor_q <= b_in;
      quo_neg_q <= quo_neg_in;
      rem_neg_q <= rem_neg_in;
    end else if (step) begin
      rq_q <= rq_next;
    end
  end

  // counter runs 31 down to 0 over the steps
  always_ff @(posedge clk) begin
    if (reset) begin
      count_q <= '0;
    end else if (load) begin
      count_q <= count_t'(iter_count - 1);
    end else if (step) begin
      count_q <= count_q - 1'b1;
    end
  end

  // only sampled by control while it is in calc
  assign last_iter = (count_q == '0);

  // ------------------------------
  // sign correction
  // ------------------------------

  operand_t quo_raw;
  operand_t rem_raw;
  operand_t quo_fix;
  operand_t rem_fix;
  result_t  res_fix;

  // taken from the final step's output, not the register
  assign quo_raw = rq_next[data_width-1:0];
  assign rem_raw = rq_next[2*data_width-1:data_width];

  assign quo_fix = quo_neg_q ? (~quo_raw + 1'b1) : quo_raw;
  assign rem_fix = rem_neg_q ? (~rem_raw + 1'b1) : rem_raw;
  assign res_fix = {rem_fix, quo_fix};

  // held until the next fix, so back-pressure keeps it stable
  always_ff @(posedge clk) begin
    if (fix) begin
      result.result <= res_fix;
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  // control never loads a new request mid-iteration
  a_load_step_excl: assert property (@(posedge clk) disable iff (reset)
    !(step && load));

  // fix only on the last step of the loop
  a_fix_on_last: assert property (@(posedge clk) disable iff (reset)
    fix |-> (step && last_iter));

endmodule

`default_nettype wire

//--- div_ctrl_pkg.sv
`default_nettype none
// ------------------------------
// control types for the iterative divider
// ------------------------------

package div_ctrl_pkg;

  // divider FSM states
  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } div_state_t;

  // one quotient bit per iteration
  localparam int iter_count = 32;

  // iteration counter, counts down to zero
  typedef logic [$clog2(iter_count)-1:0] count_t;

  // entries in the response queue
  localparam int resp_queue_depth = 2;

endpackage

`default_nettype wire

//--- div_msg_pkg.sv
`default_nettype none
// ------------------------------
// message types for the divider request/response channels
// a result keeps the remainder in the upper half and the quotient in the lower half
// ------------------------------

package div_msg_pkg;

  // ------------------------------
  // widths
  // ------------------------------

  // width of one operand
  localparam int data_width = 32;

  // one dividend or divisor
  typedef logic [data_width-1:0] operand_t;

  // {remainder, quotient}
  typedef logic [2*data_width-1:0] result_t;

  // ------------------------------
  // channel messages
  // ------------------------------

  // request message, 65 bits
  // is_signed selects two's complement handling of both operands
  typedef struct packed {
    logic     is_signed;
    operand_t a;
    operand_t b;
  } div_req_t;

  // response message
  // a single field for now, later fields go after result
  typedef struct packed {
    result_t result;
  } div_resp_t;

endpackage

`default_nettype wire
